/* logic/shared_ram_macros.svh */
// ****************************
// size constants of the shared
// data memory and its clients
// ****************************

`ifndef SHARED_RAM_MACROS_SVH
`define SHARED_RAM_MACROS_SVH

// peer clients on the arbiter
`define SR_NUM_CLIENTS 2

// depth in words
`define SR_ELS 256

// word width must be a multiple of 8 for byte masking
`define SR_WIDTH 32

`define SR_ADDR_W 8 // log2 of SR_ELS

// one write-enable bit per byte lane
`define SR_MASK_W (`SR_WIDTH / 8)

`endif

/* logic/shared_ram_pkg.sv */
// ****************************
// request and response types
// of the shared data memory
// ****************************

`default_nettype none

`include "shared_ram_macros.svh"

package shared_ram_pkg;

  // one RAM access as a client hands it over
  typedef struct packed
  {
    logic                  write; // 1 write, 0 read
    logic [`SR_ADDR_W-1:0] addr;
    logic [`SR_WIDTH-1:0]  data;  // write data that reads ignore
    logic [`SR_MASK_W-1:0] mask;  // byte lanes changed by a write
  } mem_req_t;

  typedef struct packed
  {
    logic [`SR_WIDTH-1:0] data; // read word one cycle after the access
  } mem_resp_t;

endpackage

`default_nettype wire

/* logic/byte_mask_ram.sv */
// ****************************
// two-bank synchronous 1RW RAM
// with byte write mask and a
// registered bank select
// ****************************

`timescale 1ns/1ps
`default_nettype none

`include "shared_ram_macros.svh"

module byte_mask_ram
  #(parameter int els_p   = `SR_ELS,
    parameter int width_p = `SR_WIDTH)
  (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      v_i,
    input  shared_ram_pkg::mem_req_t  req_i,
    output shared_ram_pkg::mem_resp_t resp_o
  );

  localparam int addr_w_lp    = $clog2(els_p);
  localparam int mask_w_lp    = width_p / 8;
  localparam int bank_els_lp  = els_p / 2;

  // word index inside a bank comes from the upper address bits
  logic [addr_w_lp-2:0] word_idx;
  logic                 bank_sel;
  logic                 rd;
  logic                 sel_r;

  assign word_idx = req_i.addr[addr_w_lp-1:1];
  assign bank_sel = req_i.addr[0];
  assign rd       = v_i & ~req_i.write;

  if (width_p % 8 != 0)
  begin : g_width_chk
    $error("byte_mask_ram: width_p must be a multiple of 8");
  end

  for (genvar b = 0; b < 2; b++)
  begin : bank
    logic [width_p-1:0] mem_r [bank_els_lp];
    logic [width_p-1:0] rd_r; // holds until the next read of this bank
    logic               hit;

    assign hit = v_i & (bank_sel == 1'(b));

    always_ff @(posedge clk_i)
    begin
      if (hit & req_i.write)
      begin
        for (int i = 0; i < mask_w_lp; i++)
        begin
          if (req_i.mask[i])
            mem_r[word_idx][8*i +: 8] <= req_i.data[8*i +: 8];
        end
      end
    end

    always_ff @(posedge clk_i)
    begin
      if (hit & ~req_i.write)
        rd_r <= mem_r[word_idx];
    end
  end

  // bank select follows the last read so the output stays stable
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      sel_r <= 1'b0;
    else if (rd)
      sel_r <= bank_sel;
  end

  assign resp_o.data = sel_r ? bank[1].rd_r : bank[0].rd_r;

  a_addr_range : assert property (
    @(posedge clk_i) disable iff (reset_i)
    v_i |-> (int'(req_i.addr) < els_p)
  ) else $error("byte_mask_ram: address 0x%0h beyond depth", req_i.addr);

endmodule

`default_nettype wire

/* logic/ram_arbiter.sv */
// ****************************
// round-robin arbiter in front
// of the single RAM port
// ****************************

`timescale 1ns/1ps
`default_nettype none

`include "shared_ram_macros.svh"

module ram_arbiter
  #(parameter int n_p = `SR_NUM_CLIENTS)
  (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic [n_p-1:0]                       pending_i,
    input  shared_ram_pkg::mem_req_t [n_p-1:0]   req_i,
    output logic [n_p-1:0]                       grant_o,
    output logic                                 ram_v_o,
    output shared_ram_pkg::mem_req_t             ram_req_o
  );

  localparam int ptr_w_lp = (n_p > 1) ? $clog2(n_p) : 1;

  logic [ptr_w_lp-1:0] ptr_r;  // highest-priority client this cycle
  logic [ptr_w_lp-1:0] winner;
  logic                found;

  // first pending client at or after the pointer
  always_comb
  begin
    int idx;
    grant_o = '0;
    winner  = '0;
    found   = 1'b0;
    for (int off = 0; off < n_p; off++)
    begin
      idx = (int'(ptr_r) + off) % n_p;
      if (!found && pending_i[idx])
      begin
        found  = 1'b1;
        winner = ptr_w_lp'(idx);
      end
    end
    if (found)
      grant_o[winner] = 1'b1;
  end

  assign ram_v_o   = found;
  assign ram_req_o = req_i[winner];

  // rotate past the winner so the other side goes first next time
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      ptr_r <= '0;
    else if (found)
    begin
      if (winner == ptr_w_lp'(n_p - 1))
        ptr_r <= '0;
      else
        ptr_r <= winner + 1'b1;
    end
  end

  a_grant_onehot : assert property (
    @(posedge clk_i) disable iff (reset_i)
    $onehot0(grant_o)
  ) else $error("ram_arbiter: grant not one-hot: %b", grant_o);

  a_ram_v : assert property (
    @(posedge clk_i) disable iff (reset_i)
    ram_v_o == (|grant_o)
  ) else $error("ram_arbiter: ram_v_o disagrees with grant_o");

endmodule

`default_nettype wire

/* logic/client_port.sv */
// ****************************
// one client of the shared RAM
// holds a request until granted
// ****************************

`timescale 1ns/1ps
`default_nettype none

module client_port
  (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      req_v_i,
    input  shared_ram_pkg::mem_req_t  req_i,
    input  logic                      grant_i,
    input  shared_ram_pkg::mem_resp_t ram_resp_i,
    output logic                      pending_o,
    output shared_ram_pkg::mem_req_t  held_req_o,
    output logic                      busy_o,
    output logic                      done_o,
    output shared_ram_pkg::mem_resp_t resp_o
  );

  logic                     pending_r;
  logic                     done_r;    // granted in the cycle before
  shared_ram_pkg::mem_req_t held_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pending_r <= 1'b0;
      done_r    <= 1'b0;
    end
    else
    begin
      if (req_v_i)
        pending_r <= 1'b1;
      else if (grant_i)
        pending_r <= 1'b0;
      done_r <= grant_i & pending_r; // RAM accesses on this same edge
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (req_v_i)
      held_r <= req_i;
  end

  assign pending_o  = pending_r;
  assign held_req_o = held_r;
  assign busy_o     = pending_r | done_r;
  assign done_o     = done_r;
  assign resp_o     = ram_resp_i; // read data lands with done

  a_no_strobe_busy : assert property (
    @(posedge clk_i) disable iff (reset_i)
    req_v_i |-> !busy_o
  ) else $error("client_port: request strobe while busy");

endmodule

`default_nettype wire

/* logic/shared_ram_top.sv */
// ****************************
// shared data memory top with
// client ports, arbiter and RAM
// ****************************

`timescale 1ns/1ps
`default_nettype none

`include "shared_ram_macros.svh"

module shared_ram_top
  (
    input  logic                                            clk_i,
    input  logic                                            reset_i,
    input  logic [`SR_NUM_CLIENTS-1:0]                      req_v_i,
    input  shared_ram_pkg::mem_req_t [`SR_NUM_CLIENTS-1:0]  req_i,
    output logic [`SR_NUM_CLIENTS-1:0]                      busy_o,
    output logic [`SR_NUM_CLIENTS-1:0]                      done_o,
    output shared_ram_pkg::mem_resp_t [`SR_NUM_CLIENTS-1:0] resp_o
  );

  logic [`SR_NUM_CLIENTS-1:0]                     pending;
  logic [`SR_NUM_CLIENTS-1:0]                     grant;
  shared_ram_pkg::mem_req_t [`SR_NUM_CLIENTS-1:0] held_req;
  logic                                           ram_v;
  shared_ram_pkg::mem_req_t                       ram_req;
  shared_ram_pkg::mem_resp_t                      ram_resp; // seen by every client

  for (genvar c = 0; c < `SR_NUM_CLIENTS; c++)
  begin : client
    client_port i_port
      (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .req_v_i    (req_v_i[c]),
        .req_i      (req_i[c]),
        .grant_i    (grant[c]),
        .ram_resp_i (ram_resp),
        .pending_o  (pending[c]),
        .held_req_o (held_req[c]),
        .busy_o     (busy_o[c]),
        .done_o     (done_o[c]),
        .resp_o     (resp_o[c])
      );
  end

  ram_arbiter #(.n_p(`SR_NUM_CLIENTS)) i_arb
    (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .pending_i (pending),
      .req_i     (held_req),
      .grant_o   (grant),
      .ram_v_o   (ram_v),
      .ram_req_o (ram_req)
    );

  byte_mask_ram
    #(.els_p   (`SR_ELS),
      .width_p (`SR_WIDTH))
    i_ram
    (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (ram_v),
      .req_i   (ram_req),
      .resp_o  (ram_resp)
    );

endmodule

`default_nettype wire

/* verification/shared_ram_tb.sv */
// ******************************
// testbench of the shared data
// memory with row table, reference
// model, LFSR data and watchdog
// ******************************

`timescale 1ns/1ps
`default_nettype none

`include "shared_ram_macros.svh"

module shared_ram_tb;

  localparam int num_rows_lp     = 22;
  localparam int row_cycles_lp   = 40;
  localparam int reset_cycles_lp = 16;

  // what one client does in a table row
  typedef struct packed
  {
    logic                  en;
    logic                  write;
    logic [`SR_ADDR_W-1:0] addr;
    logic [`SR_MASK_W-1:0] mask;
  } side_t;

  typedef struct packed
  {
    side_t c0;
    side_t c1;
    logic  first_done; // client expected to finish first when both strobe
  } row_t;

  logic                                            clk_i = 1'b0;
  logic                                            reset_i;
  logic [`SR_NUM_CLIENTS-1:0]                      req_v_i;
  shared_ram_pkg::mem_req_t [`SR_NUM_CLIENTS-1:0]  req_i;
  logic [`SR_NUM_CLIENTS-1:0]                      busy_o;
  logic [`SR_NUM_CLIENTS-1:0]                      done_o;
  shared_ram_pkg::mem_resp_t [`SR_NUM_CLIENTS-1:0] resp_o;

  row_t                 table_q [num_rows_lp];
  logic [`SR_WIDTH-1:0] ref_mem [`SR_ELS]; // expected RAM contents
  logic [31:0]          lfsr_q;

  shared_ram_top i_dut
    (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_v_i (req_v_i),
      .req_i   (req_i),
      .busy_o  (busy_o),
      .done_o  (done_o),
      .resp_o  (resp_o)
    );

  always #2 clk_i = ~clk_i; // 4 ns period

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  task automatic draw_word(output logic [`SR_WIDTH-1:0] w);
    for (int i = 0; i < `SR_WIDTH; i++)
    begin
      w[i]   = lfsr_q[0]; // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // bytes with a set mask bit come from the new word
  function automatic logic [`SR_WIDTH-1:0] merge_bytes(input logic [`SR_WIDTH-1:0] old_w,
                                                       input logic [`SR_WIDTH-1:0] new_w,
                                                       input logic [`SR_MASK_W-1:0] mask);
    logic [`SR_WIDTH-1:0] out_w;
    for (int i = 0; i < `SR_MASK_W; i++)
      out_w[8*i +: 8] = mask[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
    return out_w;
  endfunction

  task automatic end_in_failure();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      end_in_failure();
    end
  endtask

  function automatic side_t wr_op(input logic [`SR_ADDR_W-1:0] addr,
                                  input logic [`SR_MASK_W-1:0] mask);
    return {1'b1, 1'b1, addr, mask};
  endfunction

  function automatic side_t rd_op(input logic [`SR_ADDR_W-1:0] addr);
    return {1'b1, 1'b0, addr, {`SR_MASK_W{1'b0}}};
  endfunction

  function automatic side_t idle_op();
    return '0;
  endfunction

  task automatic load_table();
    table_q[0]  = {wr_op(8'h10, 4'hf), wr_op(8'h11, 4'hf), 1'b0}; // client 0 first after reset
    table_q[1]  = {rd_op(8'h10), idle_op(), 1'b0};
    table_q[2]  = {idle_op(), rd_op(8'h11), 1'b0};
    table_q[3]  = {wr_op(8'h10, 4'h5), idle_op(), 1'b0};
    table_q[4]  = {rd_op(8'h10), idle_op(), 1'b0};
    table_q[5]  = {idle_op(), wr_op(8'h11, 4'h8), 1'b0};
    table_q[6]  = {idle_op(), rd_op(8'h11), 1'b0};
    table_q[7]  = {rd_op(8'h10), idle_op(), 1'b0}; // alternate between banks
    table_q[8]  = {rd_op(8'h11), idle_op(), 1'b0};
    table_q[9]  = {rd_op(8'h10), idle_op(), 1'b0};
    table_q[10] = {idle_op(), rd_op(8'h11), 1'b0};
    table_q[11] = {wr_op(8'h20, 4'hf), idle_op(), 1'b0};
    table_q[12] = {idle_op(), wr_op(8'h21, 4'hf), 1'b0};
    table_q[13] = {rd_op(8'h21), rd_op(8'h20), 1'b0};
    table_q[14] = {idle_op(), wr_op(8'h20, 4'h3), 1'b0};
    table_q[15] = {rd_op(8'h20), rd_op(8'h21), 1'b0};
    table_q[16] = {wr_op(8'h30, 4'hf), idle_op(), 1'b0};
    table_q[17] = {rd_op(8'h30), wr_op(8'h30, 4'hf), 1'b1}; // write wins and the read sees the new word
    table_q[18] = {wr_op(8'h30, 4'hf), rd_op(8'h30), 1'b1}; // read wins and sees the old word
    table_q[19] = {idle_op(), rd_op(8'h30), 1'b0};
    table_q[20] = {wr_op(8'h30, 4'h6), rd_op(8'h30), 1'b0};
    table_q[21] = {rd_op(8'h30), rd_op(8'h10), 1'b0};
  endtask

  // model update or read check in the order the done pulses arrive
  task automatic finish_access(input shared_ram_pkg::mem_req_t req, input int c);
    if (req.write)
      ref_mem[req.addr] = merge_bytes(ref_mem[req.addr], req.data, req.mask);
    else
      check_value($sformatf("resp_o[%0d].data", c), resp_o[c].data, ref_mem[req.addr]);
  endtask

  task automatic run_row(input int r);
    shared_ram_pkg::mem_req_t   req [`SR_NUM_CLIENTS];
    side_t                      side;
    logic [`SR_NUM_CLIENTS-1:0] active;
    logic [`SR_NUM_CLIENTS-1:0] finished;
    logic [`SR_NUM_CLIENTS-1:0] released;
    logic [`SR_NUM_CLIENTS-1:0] fresh;
    logic [`SR_WIDTH-1:0]       wdata;
    int                         order [$];

    active = '0;
    for (int c = 0; c < `SR_NUM_CLIENTS; c++)
    begin
      side   = (c == 0) ? table_q[r].c0 : table_q[r].c1;
      req[c] = '0;
      if (side.en)
      begin
        active[c]    = 1'b1;
        req[c].write = side.write;
        req[c].addr  = side.addr;
        req[c].mask  = side.mask;
        if (side.write)
        begin
          draw_word(wdata);
          req[c].data = wdata;
        end
      end
    end

    @(negedge clk_i);
    req_v_i = active;
    for (int c = 0; c < `SR_NUM_CLIENTS; c++)
      req_i[c] = req[c];
    @(negedge clk_i);
    req_v_i = '0;
    check_value("busy_o", busy_o & active, active); // busy from the strobe edge on

    finished = '0;
    released = '0;
    while (released != active)
    begin
      check_value("done_o of idle client", done_o & ~active, '0);
      for (int c = 0; c < `SR_NUM_CLIENTS; c++)
      begin
        if (finished[c] && !released[c])
        begin
          check_value($sformatf("done_o[%0d]", c), done_o[c], 1'b0); // single-cycle pulse
          check_value($sformatf("busy_o[%0d]", c), busy_o[c], 1'b0);
          released[c] = 1'b1;
        end
      end
      fresh = done_o & active & ~finished;
      if ($countones(fresh) > 1)
      begin
        $display("Both clients signalled done in the same cycle in row %0d", r);
        end_in_failure();
      end
      for (int c = 0; c < `SR_NUM_CLIENTS; c++)
      begin
        if (fresh[c])
        begin
          finish_access(req[c], c);
          finished[c] = 1'b1;
          order.push_back(c);
        end
      end
      if (released != active)
        @(negedge clk_i);
    end

    if (&active)
      check_value("first done client", order[0], table_q[r].first_done);
  endtask

  initial
  begin
    reset_i = 1'b1;
    req_v_i = '0;
    req_i   = '0;
    lfsr_q  = 32'hf73f;
    load_table();
    repeat (reset_cycles_lp) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    check_value("busy_o", busy_o, '0);
    check_value("done_o", done_o, '0);
    for (int r = 0; r < num_rows_lp; r++)
      run_row(r);
    $display("All checks passed");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (reset_cycles_lp + num_rows_lp * row_cycles_lp) @(posedge clk_i);
    $display("Timeout: the DUT did not finish the stimulus table in time");
    end_in_failure();
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+logic
logic/shared_ram_pkg.sv
logic/byte_mask_ram.sv
logic/ram_arbiter.sv
logic/client_port.sv
logic/shared_ram_top.sv
verification/shared_ram_tb.sv
